// File: design/servant.sv
`timescale 1ns/10ps

module servant #(
   parameter int MEM_DEPTH   = 8192,
   parameter int TIMER_WIDTH = 32
) (
   input  logic        i_wb_clk,
   input  logic        i_arst_n,

   input  logic [31:0] i_ibus_adr,
   input  logic        i_ibus_cyc,
   output logic [31:0] o_ibus_rdt,
   output logic        o_ibus_ack,

   input  logic [31:0] i_dbus_adr,
   input  logic [31:0] i_dbus_dat,
   input  logic [3:0]  i_dbus_sel,
   input  logic        i_dbus_we,
   input  logic        i_dbus_cyc,
   output logic [31:0] o_dbus_rdt,
   output logic        o_dbus_ack,

   output logic        o_timer_irq,
   output logic        o_q
);

   logic [1:0]  tmr_sel;
   logic [31:0] tmr_dat;
   logic        tmr_we;
   logic [31:0] tmr_rdt;

   wb_if dmem_bus ();  // Mux to arbiter
   wb_if mem_bus ();   // Arbiter to RAM

   servant_mux mux (
      .i_wb_clk   (i_wb_clk),
      .i_arst_n   (i_arst_n),
      .i_dbus_adr (i_dbus_adr),
      .i_dbus_dat (i_dbus_dat),
      .i_dbus_sel (i_dbus_sel),
      .i_dbus_we  (i_dbus_we),
      .i_dbus_cyc (i_dbus_cyc),
      .o_dbus_rdt (o_dbus_rdt),
      .o_dbus_ack (o_dbus_ack),
      .mem        (dmem_bus.master),
      .o_tmr_sel  (tmr_sel),
      .o_tmr_dat  (tmr_dat),
      .o_tmr_we   (tmr_we),
      .i_tmr_rdt  (tmr_rdt),
      .o_q        (o_q)
   );

   servant_arbiter arbiter (
      .i_ibus_adr (i_ibus_adr),
      .i_ibus_cyc (i_ibus_cyc),
      .o_ibus_rdt (o_ibus_rdt),
      .o_ibus_ack (o_ibus_ack),
      .dbus       (dmem_bus.slave),
      .mem        (mem_bus.master)
   );

   servant_ram #(.MEM_DEPTH(MEM_DEPTH)) ram (
      .i_wb_clk (i_wb_clk),
      .i_arst_n (i_arst_n),
      .mem      (mem_bus.slave)
   );

   servant_timer #(.TIMER_WIDTH(TIMER_WIDTH)) timer (
      .i_wb_clk (i_wb_clk),
      .i_arst_n (i_arst_n),
      .i_sel    (tmr_sel),
      .i_dat    (tmr_dat),
      .i_we     (tmr_we),
      .o_rdt    (tmr_rdt),
      .o_irq    (o_timer_irq)
   );

endmodule

// File: design/servant_arbiter.sv
`timescale 1ns/10ps

module servant_arbiter
   import servant_pkg::*;
(
   input  bus_addr_u   i_ibus_adr,
   input  logic        i_ibus_cyc,
   output logic [31:0] o_ibus_rdt,
   output logic        o_ibus_ack,

   wb_if.slave         dbus,
   wb_if.master        mem
);

   logic dbus_owns;

   // Data bus wins whenever it asks
   assign dbus_owns = dbus.cyc;

   assign mem.adr = dbus_owns ? dbus.adr : i_ibus_adr;
   assign mem.dat = dbus.dat;
   assign mem.sel = dbus_owns ? dbus.sel : 4'b1111;
   assign mem.we  = dbus_owns & dbus.we;  // Ibus only reads
   assign mem.cyc = dbus.cyc | i_ibus_cyc;

   assign dbus.rdt = mem.rdt;
   assign dbus.ack = mem.ack & dbus_owns;

   assign o_ibus_rdt = mem.rdt;
   assign o_ibus_ack = mem.ack & ~dbus_owns & i_ibus_cyc;  // Loser sees no ack

endmodule

// File: design/servant_mux.sv
`timescale 1ns/10ps

module servant_mux
   import servant_pkg::*;
(
   input  logic        i_wb_clk,
   input  logic        i_arst_n,

   input  bus_addr_u   i_dbus_adr,
   input  logic [31:0] i_dbus_dat,
   input  logic [3:0]  i_dbus_sel,
   input  logic        i_dbus_we,
   input  logic        i_dbus_cyc,
   output logic [31:0] o_dbus_rdt,
   output logic        o_dbus_ack,

   wb_if.master        mem,

   output logic [1:0]  o_tmr_sel,
   output logic [31:0] o_tmr_dat,
   output logic        o_tmr_we,
   input  logic [31:0] i_tmr_rdt,

   output logic        o_q
);

   logic        is_ram;
   logic        io_cyc;
   logic        io_ack;
   logic        io_wr;
   logic        gpio_q;
   logic [31:0] io_rdt;

   assign is_ram = (i_dbus_adr.io.region == REGION_RAM);
   assign io_cyc = i_dbus_cyc & ~is_ram;
   assign io_wr  = io_ack & io_cyc & i_dbus_we;  // Acknowledged write

   assign mem.adr = i_dbus_adr;
   assign mem.dat = i_dbus_dat;
   assign mem.sel = i_dbus_sel;
   assign mem.we  = i_dbus_we;
   assign mem.cyc = i_dbus_cyc & is_ram;

   always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         io_ack <= 1'b0;
         gpio_q <= 1'b0;
      end else begin
         io_ack <= io_cyc & ~io_ack;  // No back-to-back ack
         if (io_wr && i_dbus_adr.io.region == REGION_GPIO)
            gpio_q <= i_dbus_dat[0];
      end
   end

   always_comb begin
      case (i_dbus_adr.io.region)
         REGION_GPIO:  io_rdt = {31'd0, gpio_q};
         REGION_TIMER: io_rdt = i_tmr_rdt;
         REGION_NONE:  io_rdt = 32'd0;  // Unmapped reads as zero
         default:      io_rdt = 32'd0;
      endcase
   end

   assign o_dbus_rdt = is_ram ? mem.rdt : io_rdt;
   assign o_dbus_ack = is_ram ? mem.ack : (io_ack & io_cyc);

   assign o_tmr_sel = i_dbus_adr.io.reg_sel;
   assign o_tmr_dat = i_dbus_dat;
   assign o_tmr_we  = io_wr & (i_dbus_adr.io.region == REGION_TIMER);

   assign o_q = gpio_q;

endmodule

// File: design/servant_pkg.sv
package servant_pkg;

   localparam logic [1:0] REGION_RAM   = 2'd0;  // 0x0000_0000
   localparam logic [1:0] REGION_GPIO  = 2'd1;  // 0x4000_0000
   localparam logic [1:0] REGION_TIMER = 2'd2;  // 0x8000_0000
   localparam logic [1:0] REGION_NONE  = 2'd3;  // 0xC000_0000

   localparam logic [1:0] TMR_MTIME    = 2'd0;
   localparam logic [1:0] TMR_MTIMECMP = 2'd1;

   // Address as seen by memory targets
   typedef struct packed {
      logic [1:0]  region;
      logic [27:0] word;
      logic [1:0]  offset;
   } mem_view_t;

   // Address as seen by register targets
   typedef struct packed {
      logic [1:0]  region;
      logic [25:0] unused;
      logic [1:0]  reg_sel;
      logic [1:0]  offset;
   } io_view_t;

   typedef union packed {
      mem_view_t mem;
      io_view_t  io;
   } bus_addr_u;

endpackage

// File: design/servant_ram.sv
`timescale 1ns/10ps

module servant_ram #(
   parameter int MEM_DEPTH = 8192
) (
   input  logic i_wb_clk,
   input  logic i_arst_n,
   wb_if.slave  mem
);

   localparam int WORDS = MEM_DEPTH / 4;
   localparam int AW    = $clog2(WORDS);

   logic [31:0]   ram_q [WORDS];
   logic [31:0]   rdt_q;
   logic          ack_q;
   logic [AW-1:0] word_adr;
   logic          access;

   assign word_adr = mem.adr.mem.word[AW-1:0];

   // Ignore the held cyc that follows an ack
   assign access = mem.cyc & ~ack_q;

   always_ff @(posedge i_wb_clk) begin
      if (access) begin
         if (mem.we) begin
            for (int i = 0; i < 4; i++) begin
               if (mem.sel[i])
                  ram_q[word_adr][8*i +: 8] <= mem.dat[8*i +: 8];
            end
         end
         rdt_q <= ram_q[word_adr];  // Old data on a write
      end
   end

   always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
      if (!i_arst_n)
         ack_q <= 1'b0;
      else
         ack_q <= access;
   end

   assign mem.rdt = rdt_q;
   assign mem.ack = ack_q;

endmodule

// File: design/servant_timer.sv
`timescale 1ns/10ps

module servant_timer
   import servant_pkg::*;
#(
   parameter int TIMER_WIDTH = 32
) (
   input  logic        i_wb_clk,
   input  logic        i_arst_n,
   input  logic [1:0]  i_sel,
   input  logic [31:0] i_dat,
   input  logic        i_we,
   output logic [31:0] o_rdt,
   output logic        o_irq
);

   logic [TIMER_WIDTH-1:0] mtime;
   logic [TIMER_WIDTH-1:0] mtimecmp;

   always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         mtime    <= '0;
         mtimecmp <= '1;  // Keeps irq quiet out of reset
      end else begin
         if (i_we && i_sel == TMR_MTIME)
            mtime <= i_dat[TIMER_WIDTH-1:0];
         else
            mtime <= mtime + 1'b1;

         if (i_we && i_sel == TMR_MTIMECMP)
            mtimecmp <= i_dat[TIMER_WIDTH-1:0];
      end
   end

   always_comb begin
      case (i_sel)
         TMR_MTIME:    o_rdt = 32'(mtime);
         TMR_MTIMECMP: o_rdt = 32'(mtimecmp);
         default:      o_rdt = 32'd0;
      endcase
   end

   // Unsigned compare, level output
   assign o_irq = (mtime >= mtimecmp);

endmodule

// File: design/wb_if.sv
`timescale 1ns/10ps

interface wb_if
   import servant_pkg::*;
   ();

   bus_addr_u   adr;
   logic [31:0] dat;
   logic [3:0]  sel;
   logic        we;
   logic        cyc;
   logic [31:0] rdt;
   logic        ack;   // One cycle pulse per request

   modport master (
      output adr, dat, sel, we, cyc,
      input  rdt, ack
   );

   modport slave (
      input  adr, dat, sel, we, cyc,
      output rdt, ack
   );

endinterface

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module servant_tb \
   -f src.f -o servant_sim

# Simulator status is not trusted alone, the log decides
./obj_dir/servant_sim 2>&1 | tee sim.log

if grep -qF "*** PASSED ***" sim.log; then
   echo "Simulation result: pass"
else
   echo "Simulation result: fail"
   exit 1
fi

// File: src.f
design/servant_pkg.sv
design/wb_if.sv
design/servant_arbiter.sv
design/servant_mux.sv
design/servant_ram.sv
design/servant_timer.sv
design/servant.sv
test/servant_chk.sv
test/servant_tb.sv

// File: test/servant_chk.sv
`timescale 1ns/10ps

module servant_chk (
   input logic i_wb_clk,
   input logic i_arst_n,
   input logic i_ibus_cyc,
   input logic i_ibus_ack,
   input logic i_dbus_cyc,
   input logic i_dbus_ack,
   input logic i_q,
   input logic i_timer_irq
);

   // Ack answers a live request only
   dbus_ack_in_cyc: assert property (@(posedge i_wb_clk) disable iff (!i_arst_n)
      i_dbus_ack |-> i_dbus_cyc)
      else $error("dbus ack without cyc");

   ibus_ack_in_cyc: assert property (@(posedge i_wb_clk) disable iff (!i_arst_n)
      i_ibus_ack |-> i_ibus_cyc)
      else $error("ibus ack without cyc");

   dbus_ack_single: assert property (@(posedge i_wb_clk) disable iff (!i_arst_n)
      i_dbus_ack |=> !i_dbus_ack)
      else $error("dbus ack two cycles in a row");

   ibus_ack_single: assert property (@(posedge i_wb_clk) disable iff (!i_arst_n)
      i_ibus_ack |=> !i_ibus_ack)
      else $error("ibus ack two cycles in a row");

   // One RAM port, one winner
   acks_exclusive: assert property (@(posedge i_wb_clk) disable iff (!i_arst_n)
      !(i_ibus_ack && i_dbus_ack))
      else $error("ibus and dbus ack together");

   reset_outputs: assert property (@(posedge i_wb_clk)
      !i_arst_n |-> (!i_q && !i_timer_irq))
      else $error("o_q or o_timer_irq high in reset");

endmodule

bind servant servant_chk chk (
   .i_wb_clk    (i_wb_clk),
   .i_arst_n    (i_arst_n),
   .i_ibus_cyc  (i_ibus_cyc),
   .i_ibus_ack  (o_ibus_ack),
   .i_dbus_cyc  (i_dbus_cyc),
   .i_dbus_ack  (o_dbus_ack),
   .i_q         (o_q),
   .i_timer_irq (o_timer_irq)
);

// File: test/servant_tb.sv
`timescale 1ns/10ps

module servant_tb;

   localparam int CLK_PERIOD = 100;
   localparam int N_WORDS    = 64;   // RAM window under test
   localparam int N_RAM      = 300;
   localparam int N_IBUS     = 100;
   localparam int N_SIM      = 50;
   localparam int N_GPIO     = 40;
   localparam int N_TMR      = 3;
   localparam int POLL_MAX   = 100;
   localparam int ACK_LIMIT  = 8;
   localparam int N_TRANS    = N_WORDS + 2 * N_RAM + N_IBUS + N_SIM + 5 * N_GPIO
                               + N_TMR * (POLL_MAX + 3);
   localparam int CYC_BOUND  = 6;    // Worst case cycles per transaction
   localparam logic [31:0] TMR_BASE = 32'h8000_0000;

   logic        clk;
   logic        arst_n;
   logic [31:0] ibus_adr;
   logic        ibus_cyc;
   logic [31:0] ibus_rdt;
   logic        ibus_ack;
   logic [31:0] dbus_adr;
   logic [31:0] dbus_dat;
   logic [3:0]  dbus_sel;
   logic        dbus_we;
   logic        dbus_cyc;
   logic [31:0] dbus_rdt;
   logic        dbus_ack;
   logic        timer_irq;
   logic        o_q;

   logic [31:0] rng;
   logic [31:0] model [N_WORDS];
   logic        gpio;
   logic        irq_at_ack;  // Irq seen with the last dbus ack
   int          errors;

   servant UUT (
      .i_wb_clk    (clk),
      .i_arst_n    (arst_n),
      .i_ibus_adr  (ibus_adr),
      .i_ibus_cyc  (ibus_cyc),
      .o_ibus_rdt  (ibus_rdt),
      .o_ibus_ack  (ibus_ack),
      .i_dbus_adr  (dbus_adr),
      .i_dbus_dat  (dbus_dat),
      .i_dbus_sel  (dbus_sel),
      .i_dbus_we   (dbus_we),
      .i_dbus_cyc  (dbus_cyc),
      .o_dbus_rdt  (dbus_rdt),
      .o_dbus_ack  (dbus_ack),
      .o_timer_irq (timer_irq),
      .o_q         (o_q)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   function automatic logic [31:0] ram_adr(input int w);
      return 32'(w) << 2;
   endfunction

   // Byte lanes under sel take the new data
   function automatic void model_write(input int w, input logic [31:0] d,
                                       input logic [3:0] sel);
      for (int i = 0; i < 4; i++) begin
         if (sel[i])
            model[w][8*i +: 8] = d[8*i +: 8];
      end
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_eq(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         abort_run($sformatf("ERR %0t ns: %s got %08h expected %08h",
                             $time, what, got, exp));
      end
   endtask

   task automatic dbus_xfer(input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, input logic we,
                            output logic [31:0] rdt, output int waits);
      waits = 0;
      @(posedge clk);
      dbus_adr <= adr;
      dbus_dat <= dat;
      dbus_sel <= sel;
      dbus_we  <= we;
      dbus_cyc <= 1'b1;
      do begin
         @(negedge clk);
         waits++;
         if (waits > ACK_LIMIT)
            abort_run("No data bus ack within the cycle limit");
      end while (!dbus_ack);
      rdt        = dbus_rdt;
      irq_at_ack = timer_irq;
      @(posedge clk);
      dbus_cyc <= 1'b0;
   endtask

   task automatic ibus_read(input logic [31:0] adr, output logic [31:0] rdt,
                            output int waits);
      waits = 0;
      @(posedge clk);
      ibus_adr <= adr;
      ibus_cyc <= 1'b1;
      do begin
         @(negedge clk);
         waits++;
         if (waits > ACK_LIMIT)
            abort_run("No instruction bus ack within the cycle limit");
      end while (!ibus_ack);
      rdt = ibus_rdt;
      @(posedge clk);
      ibus_cyc <= 1'b0;
   endtask

   task automatic dbus_write(input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
      logic [31:0] old;
      int          waits;
      dbus_xfer(adr, dat, sel, 1'b1, old, waits);
      check_eq("dbus write latency", waits, 2);
   endtask

   task automatic dbus_read(input logic [31:0] adr, output logic [31:0] rdt);
      int waits;
      dbus_xfer(adr, 32'd0, 4'hf, 1'b0, rdt, waits);
      check_eq("dbus read latency", waits, 2);
   endtask

   initial begin
      #((N_TRANS * CYC_BOUND + 20) * CLK_PERIOD);
      abort_run("Watchdog expired before the tests finished");
   end

   initial begin
      logic [31:0] d;
      logic [31:0] r;
      logic [31:0] dr;
      logic [31:0] ir;
      logic [31:0] cmp;
      logic [31:0] prev_t;
      logic [3:0]  sel;
      logic        we;
      int          w;
      int          iw;
      int          dwaits;
      int          iwaits;
      int          polls;
      rng      = 32'h271cd6be;
      errors   = 0;
      gpio     = 1'b0;
      arst_n   = 1'b1;
      ibus_adr = '0;
      ibus_cyc = 1'b0;
      dbus_adr = '0;
      dbus_dat = '0;
      dbus_sel = '0;
      dbus_we  = 1'b0;
      dbus_cyc = 1'b0;
      #10 arst_n = 1'b0;
      repeat (8) @(posedge clk);
      arst_n <= 1'b1;
      @(negedge clk);
      check_eq("o_q after reset", 32'(o_q), 0);
      check_eq("irq after reset", 32'(timer_irq), 0);
      check_eq("acks after reset", 32'(ibus_ack | dbus_ack), 0);

      for (int i = 0; i < N_WORDS; i++) begin  // Defined contents first
         d = next_rand();
         dbus_write(ram_adr(i), d, 4'hf);
         model[i] = d;
      end

      for (int n = 0; n < N_RAM; n++) begin
         w   = int'(next_rand() % N_WORDS);
         d   = next_rand();
         r   = next_rand();
         sel = r[3:0];
         if (r[8]) begin
            dbus_write(ram_adr(w), d, sel);
            model_write(w, d, sel);
         end
         dbus_read(ram_adr(w), r);
         check_eq("RAM read", r, model[w]);
      end

      for (int n = 0; n < N_IBUS; n++) begin
         w = int'(next_rand() % N_WORDS);
         ibus_read(ram_adr(w), r, iwaits);
         check_eq("ibus read", r, model[w]);
         check_eq("ibus latency", iwaits, 2);
      end

      for (int n = 0; n < N_SIM; n++) begin
         w   = int'(next_rand() % N_WORDS);
         iw  = int'(next_rand() % N_WORDS);
         d   = next_rand();
         r   = next_rand();
         we  = r[0];
         sel = r[7:4];
         fork
            dbus_xfer(ram_adr(w), d, sel, we, dr, dwaits);
            ibus_read(ram_adr(iw), ir, iwaits);
         join
         if (we)
            model_write(w, d, sel);
         else
            check_eq("contested dbus read", dr, model[w]);
         check_eq("contested ibus read", ir, model[iw]);
         check_eq("dbus served first", dwaits, 2);
         check_eq("ibus ack later", 32'(iwaits > dwaits), 1);
      end

      for (int n = 0; n < N_GPIO; n++) begin
         d = next_rand();
         dbus_write(32'h4000_0000 | (next_rand() & 32'h3fff_fffc), d, 4'hf);
         gpio = d[0];
         @(negedge clk);
         check_eq("o_q after GPIO write", 32'(o_q), 32'(gpio));
         dbus_read(32'h4000_0000, r);
         check_eq("GPIO read", r, {31'd0, gpio});
         w = int'(next_rand() % N_WORDS);
         dbus_write(32'hc000_0000 | ram_adr(w), next_rand(), 4'hf);  // Same word bits as w
         @(negedge clk);
         check_eq("o_q after unmapped write", 32'(o_q), 32'(gpio));
         dbus_read(32'hc000_0000 | (next_rand() & 32'h3fff_fffc), r);
         check_eq("unmapped read", r, 32'd0);
         dbus_read(ram_adr(w), r);
         check_eq("RAM after unmapped write", r, model[w]);
      end

      prev_t = 32'd0;
      for (int n = 0; n < N_TMR; n++) begin
         dbus_read(TMR_BASE, r);
         check_eq("mtime increasing", 32'(r > prev_t), 1);
         prev_t = r;
         cmp    = r + 50 + (next_rand() % 151);
         dbus_write(TMR_BASE + 4, cmp, 4'hf);
         @(negedge clk);
         check_eq("irq before mtimecmp", 32'(timer_irq), 0);
         dbus_read(TMR_BASE + 4, r);
         check_eq("mtimecmp readback", r, cmp);
         polls = 0;
         do begin
            dbus_read(TMR_BASE, r);
            check_eq("mtime increasing", 32'(r > prev_t), 1);
            check_eq("irq against mtime", 32'(irq_at_ack), 32'(r >= cmp));
            prev_t = r;
            polls++;
            if (polls > POLL_MAX)
               abort_run("mtime never reached mtimecmp");
         end while (r < cmp);
         @(negedge clk);
         check_eq("irq after mtimecmp", 32'(timer_irq), 1);
      end

      if (errors == 0) begin
         $display("*** PASSED ***");
         $finish;
      end else begin
         $display("*** FAILED ***");
         $fatal(1, "checks failed");
      end
   end

endmodule
